// File: tb/testdata_exec.txt
# chk grp f3 inv ovr op1 op2 rd2 jal br pred link pc_next pc_target, then expected
# result pc_select pc_target wdata wsel; chk bit0 result, bit1 branch, bit2 store
1 0 0 0 0 00000005 00000007 0 0 0 0 0 0 0 0000000c 0 0 0 0
1 0 0 0 0 ffffffff 00000001 0 0 0 0 0 0 0 00000000 0 0 0 0
1 0 0 1 0 00000005 00000007 0 0 0 0 0 0 0 fffffffe 0 0 0 0
1 0 0 1 0 80000000 00000001 0 0 0 0 0 0 0 7fffffff 0 0 0 0
1 1 1 0 0 00000001 0000001f 0 0 0 0 0 0 0 80000000 0 0 0 0
1 1 5 0 0 80000000 00000004 0 0 0 0 0 0 0 08000000 0 0 0 0
1 1 5 1 0 80000000 00000004 0 0 0 0 0 0 0 f8000000 0 0 0 0
1 1 1 0 0 0000000f 00000024 0 0 0 0 0 0 0 000000f0 0 0 0 0
1 2 4 0 0 f0f0f0f0 ff00ff00 0 0 0 0 0 0 0 0ff00ff0 0 0 0 0
1 2 6 0 0 f0f0f0f0 0f0f0000 0 0 0 0 0 0 0 fffff0f0 0 0 0 0
1 2 7 0 0 f0f0f0f0 ff00ff00 0 0 0 0 0 0 0 f000f000 0 0 0 0
1 3 2 1 0 ffffffff 00000001 0 0 0 0 0 0 0 00000001 0 0 0 0
1 3 3 1 0 ffffffff 00000001 0 0 0 0 0 0 0 00000000 0 0 0 0
1 3 2 1 0 7fffffff 80000000 0 0 0 0 0 0 0 00000000 0 0 0 0
1 3 3 1 0 00000001 80000000 0 0 0 0 0 0 0 00000001 0 0 0 0
1 2 4 0 1 00000010 00000020 0 0 0 0 0 0 0 00000030 0 0 0 0
1 4 0 0 0 00000007 00000006 0 0 0 0 0 0 0 0000002a 0 0 0 0
1 4 0 0 0 ffffffff ffffffff 0 0 0 0 0 0 0 00000001 0 0 0 0
1 4 1 0 0 ffffffff ffffffff 0 0 0 0 0 0 0 00000000 0 0 0 0
1 4 1 0 0 80000000 80000000 0 0 0 0 0 0 0 40000000 0 0 0 0
1 4 2 0 0 ffffffff ffffffff 0 0 0 0 0 0 0 ffffffff 0 0 0 0
1 4 3 0 0 ffffffff ffffffff 0 0 0 0 0 0 0 fffffffe 0 0 0 0
1 4 1 0 0 7fffffff 80000000 0 0 0 0 0 0 0 c0000000 0 0 0 0
1 4 3 0 0 80000000 00000002 0 0 0 0 0 0 0 00000001 0 0 0 0
2 0 0 1 0 00000005 00000005 0 0 1 0 0 00000104 00000200 0 1 00000200 0 0
2 0 0 1 0 00000005 00000005 0 0 1 1 0 00000104 00000200 0 0 00000200 0 0
2 0 1 1 0 00000005 00000005 0 0 1 1 0 00000104 00000200 0 1 00000104 0 0
2 0 1 1 0 00000005 00000005 0 0 1 0 0 00000104 00000200 0 0 00000104 0 0
2 0 4 1 0 ffffffff 00000001 0 0 1 0 0 00000104 00000200 0 1 00000200 0 0
2 0 5 1 0 ffffffff 00000001 0 0 1 0 0 00000104 00000200 0 0 00000104 0 0
2 0 6 1 0 ffffffff 00000001 0 0 1 1 0 00000104 00000200 0 1 00000104 0 0
2 0 7 1 0 ffffffff 00000001 0 0 1 1 0 00000104 00000200 0 0 00000200 0 0
3 0 0 0 0 00000000 00000000 0 1 0 0 1 00000104 00000200 00000104 1 00000200 0 0
3 0 0 0 0 00000000 00000000 0 1 0 1 1 00000104 00000200 00000104 0 00000200 0 0
5 0 0 0 0 00001000 00000000 a1b2c3d4 0 0 0 0 0 0 00001000 0 0 d4d4d4d4 1
5 0 0 0 0 00001000 00000001 a1b2c3d4 0 0 0 0 0 0 00001001 0 0 d4d4d4d4 2
5 0 0 0 0 00001000 00000002 a1b2c3d4 0 0 0 0 0 0 00001002 0 0 d4d4d4d4 4
5 0 0 0 0 00001000 00000003 a1b2c3d4 0 0 0 0 0 0 00001003 0 0 d4d4d4d4 8
5 0 1 0 0 00001000 00000000 a1b2c3d4 0 0 0 0 0 0 00001000 0 0 c3d4c3d4 3
5 0 1 0 0 00001000 00000002 a1b2c3d4 0 0 0 0 0 0 00001002 0 0 c3d4c3d4 c
5 0 2 0 0 00001000 00000004 a1b2c3d4 0 0 0 0 0 0 00001004 0 0 a1b2c3d4 f

// File: build.f
rtl/rv_exec_pkg.sv
rtl/rv_adder.sv
rtl/rv_bitwise.sv
rtl/rv_multiplier.sv
rtl/rv_alu_mux.sv
rtl/rv_branch_unit.sv
rtl/rv_store_align.sv
rtl/rv_exec_stage.sv
tb/tb_rv_exec_stage.sv

// File: tb/tb_rv_exec_stage.sv
`default_nettype none

module tb_rv_exec_stage;

    timeunit 1ns;
    timeprecision 100ps;

    logic                        i_clk;
    logic                        i_arst_n;
    logic                        i_flush;
    logic [31:0]                 i_op1;
    logic [31:0]                 i_op2;
    logic [31:0]                 i_reg_data2;
    rv_exec_pkg::alu_group_e     i_group;
    logic                        i_op2_inverse;
    logic                        i_add_override;
    logic [2:0]                  i_funct3;
    logic                        i_store;
    logic                        i_reg_write;
    logic [4:0]                  i_rd;
    logic                        i_jal;
    logic                        i_branch;
    logic [31:0]                 i_pc;
    logic [31:0]                 i_pc_next;
    logic [31:0]                 i_pc_target;
    logic                        i_branch_pred;
    logic                        i_link;
    logic                        o_ready;
    logic [31:0]                 o_result;
    logic [31:0]                 o_add;
    logic                        o_store;
    logic                        o_reg_write;
    logic [4:0]                  o_rd;
    logic [31:0]                 o_pc;
    logic                        o_pc_select;
    logic [31:0]                 o_pc_target;
    logic [31:0]                 o_wdata;
    logic [3:0]                  o_wsel;
    logic [2:0]                  o_funct3;

    logic [31:0] v [0:18];  // one vector, columns as in the data file
    int          errors;
    int          tests;
    int          seed;
    bit          timed_out;

    always #2 i_clk = ~i_clk;

    rv_exec_stage i_dut (.*);

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // called 1 ns after a rising edge, returns at the same phase
    task automatic run_vector(input string name);
        int          errs_before;
        int          waits;
        logic [4:0]  rd_exp;
        logic [31:0] pc_exp;
        logic [31:0] add_exp;
        errs_before    = errors;
        rd_exp         = tests[4:0];
        pc_exp         = {tests[29:0], 2'b00};
        add_exp        = v[3][0] ? v[5] - v[6] : v[5] + v[6];  // subtract on op2 inverse
        i_store        = v[0][2];
        i_reg_write    = ~v[0][2];
        i_rd           = rd_exp;
        i_pc           = pc_exp;
        i_group        = rv_exec_pkg::alu_group_e'(v[1][2:0]);
        i_funct3       = v[2][2:0];
        i_op2_inverse  = v[3][0];
        i_add_override = v[4][0];
        i_op1          = v[5];
        i_op2          = v[6];
        i_reg_data2    = v[7];
        i_jal          = v[8][0];
        i_branch       = v[9][0];
        i_branch_pred  = v[10][0];
        i_link         = v[11][0];
        i_pc_next      = v[12];
        i_pc_target    = v[13];
        @(posedge i_clk);
        #1;
        if (v[1][2:0] == rv_exec_pkg::GRP_MUL)
        begin
            i_group = rv_exec_pkg::GRP_ARITH;  // no second multiply on the ready edge
            for (int c = 1; c <= 33; c++)
            begin
                assert (o_ready === 1'b0)
                else
                begin
                    errors++;
                    $display("o_ready was high in cycle %0d of a multiply at %0t", c, $time);
                end
                if (c < 33)
                begin
                    @(posedge i_clk);
                    #1;
                end
            end
        end
        else
        begin
            assert (o_ready === 1'b1)
            else
            begin
                errors++;
                $display("o_ready dropped on a single-cycle op at %0t", $time);
            end
            check_val({name, " add"}, o_add, add_exp);
        end
        if (v[0][0])
            check_val({name, " result"}, o_result, v[14]);
        if (v[0][1])
        begin
            check_val({name, " pc_select"}, {31'd0, o_pc_select}, v[15]);
            check_val({name, " pc_target"}, o_pc_target, v[16]);
        end
        if (v[0][2])
        begin
            check_val({name, " wdata"}, o_wdata, v[17]);
            check_val({name, " wsel"}, {28'd0, o_wsel}, v[18]);
        end
        check_val({name, " store"}, {31'd0, o_store}, {31'd0, v[0][2]});
        check_val({name, " reg_write"}, {31'd0, o_reg_write}, {31'd0, ~v[0][2]});
        check_val({name, " rd"}, {27'd0, o_rd}, {27'd0, rd_exp});
        check_val({name, " pc"}, o_pc, pc_exp);
        check_val({name, " funct3"}, {29'd0, o_funct3}, {29'd0, v[2][2:0]});
        if (v[1][2:0] == rv_exec_pkg::GRP_MUL)
        begin
            waits = 0;
            while (o_ready !== 1'b1 && waits < 40)
            begin
                @(posedge i_clk);
                #1;
                waits++;
            end
            if (o_ready !== 1'b1)
            begin
                errors++;
                timed_out = 1'b1;
                $display("o_ready never came back after a multiply");
            end
            else
            begin
                assert (waits == 1)
                else
                begin
                    errors++;
                    $display("o_ready stayed low %0d extra cycles after the product", waits - 1);
                end
            end
        end
        tests++;
        $display("test %0d %s %s", tests, name, (errors == errs_before) ? "ok" : "FAILED");
    endtask

    // ####################
    // main sequence

    initial
    begin
        int          fd;
        int          n;
        int          waits;
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        reg [8*256-1:0] line;
        i_clk = 0;
        i_arst_n = 0;
        i_flush = 0;
        i_op1 = '0;
        i_op2 = '0;
        i_reg_data2 = '0;
        i_group = rv_exec_pkg::GRP_ARITH;
        i_op2_inverse = 0;
        i_add_override = 0;
        i_funct3 = '0;
        i_store = 0;
        i_reg_write = 0;
        i_rd = 5'd3;
        i_jal = 0;
        i_branch = 0;
        i_pc = 32'h100;
        i_pc_next = '0;
        i_pc_target = '0;
        i_branch_pred = 0;
        i_link = 0;
        errors = 0;
        tests = 0;
        seed = 32'hf956bb7f;
        timed_out = 0;

        repeat (16) @(posedge i_clk);
        #1;
        i_arst_n = 1;
        assert (o_ready === 1'b1 && o_store === 1'b0 && o_reg_write === 1'b0
                && o_pc_select === 1'b0)
        else
        begin
            errors++;
            $display("outputs not in their reset state after reset");
        end
        tests++;
        $display("test %0d reset state done", tests);

        fd = $fopen("tb/testdata_exec.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("could not open the test data file");
        end
        else
        begin
            while (!$feof(fd) && !timed_out)
            begin
                line = '0;
                void'($fgets(line, fd));
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                            v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18]);
                if (n == 19)  // comment and blank lines fall through
                    run_vector("file vector");
            end
            $fclose(fd);
        end

        // random add, sub and xor
        for (int k = 0; k < 16 && !timed_out; k++)
        begin
            r = $random(seed);
            a = $random(seed);
            b = $random(seed);
            for (int c = 0; c < 19; c++)
                v[c] = '0;
            v[0] = 32'h1;
            v[5] = a;
            v[6] = b;
            case (r[1:0])
                2'd0:    v[14] = a + b;
                2'd1:
                begin
                    v[3]  = 32'h1;
                    v[14] = a - b;
                end
                default:
                begin
                    v[1]  = rv_exec_pkg::GRP_BITS;
                    v[2]  = rv_exec_pkg::F3_XOR;
                    v[14] = a ^ b;
                end
            endcase
            run_vector("random vector");
        end

        // flush in the middle of a multiply
        if (!timed_out)
        begin
            i_group = rv_exec_pkg::GRP_MUL;
            i_funct3 = rv_exec_pkg::F3_MUL;
            i_op1 = 32'd3;
            i_op2 = 32'd5;
            i_reg_write = 1;
            @(posedge i_clk);
            #1;
            i_group = rv_exec_pkg::GRP_ARITH;
            i_reg_write = 0;
            repeat (5) @(posedge i_clk);
            #1;
            i_flush = 1;
            waits = 0;
            while (o_ready !== 1'b1 && waits < 2)
            begin
                @(posedge i_clk);
                #1;
                waits++;
            end
            i_flush = 0;
            assert (o_ready === 1'b1 && o_reg_write === 1'b0)
            else
            begin
                errors++;
                $display("flush did not abort the multiply within two cycles");
            end
            tests++;
            $display("test %0d flush during multiply done", tests);
        end

        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/rv_exec_stage.sv
`default_nettype none

module rv_exec_stage
(
    input  wire                                  i_clk,
    input  wire                                  i_arst_n,
    input  wire                                  i_flush,
    input  wire  [rv_exec_pkg::XLEN-1:0]         i_op1,
    input  wire  [rv_exec_pkg::XLEN-1:0]         i_op2,
    input  wire  [rv_exec_pkg::XLEN-1:0]         i_reg_data2,
    input  rv_exec_pkg::alu_group_e              i_group,
    input  wire                                  i_op2_inverse,
    input  wire                                  i_add_override,
    input  wire  [2:0]                           i_funct3,
    input  wire                                  i_store,
    input  wire                                  i_reg_write,
    input  wire  [4:0]                           i_rd,
    input  wire                                  i_jal,
    input  wire                                  i_branch,
    input  wire  [rv_exec_pkg::IADDR_BITS-1:0]   i_pc,
    input  wire  [rv_exec_pkg::IADDR_BITS-1:0]   i_pc_next,
    input  wire  [rv_exec_pkg::IADDR_BITS-1:0]   i_pc_target,
    input  wire                                  i_branch_pred,
    input  wire                                  i_link,
    output logic                                 o_ready,
    output logic [rv_exec_pkg::XLEN-1:0]         o_result,
    output logic [rv_exec_pkg::XLEN-1:0]         o_add,
    output logic                                 o_store,
    output logic                                 o_reg_write,
    output logic [4:0]                           o_rd,
    output logic [rv_exec_pkg::IADDR_BITS-1:0]   o_pc,
    output logic                                 o_pc_select,
    output logic [rv_exec_pkg::IADDR_BITS-1:0]   o_pc_target,
    output logic [rv_exec_pkg::XLEN-1:0]         o_wdata,
    output logic [3:0]                           o_wsel,
    output logic [2:0]                           o_funct3
);

    logic [rv_exec_pkg::XLEN-1:0]       op1, op2, reg_data2;
    logic [rv_exec_pkg::IADDR_BITS-1:0] pc, pc_next, pc_target;
    logic [2:0]                         funct3;
    logic [4:0]                         rd;
    logic                               op2_inverse, add_override, link;
    logic                               store, reg_write, jal, branch, branch_pred;
    rv_exec_pkg::alu_group_e            group;

    rv_exec_pkg::exec_state_e           state, state_next;
    logic [rv_exec_pkg::STEP_BITS-1:0]  step_cnt;
    logic                               ready;

    // ####################
    // sequencer

    always_comb
    begin
        case (state)
            rv_exec_pkg::ST_IDLE:
                state_next = (i_group == rv_exec_pkg::GRP_MUL) ? rv_exec_pkg::ST_BUSY
                                                               : rv_exec_pkg::ST_IDLE;
            rv_exec_pkg::ST_BUSY:
                state_next = (step_cnt == rv_exec_pkg::STEP_LAST) ? rv_exec_pkg::ST_DONE
                                                                  : rv_exec_pkg::ST_BUSY;
            default: state_next = rv_exec_pkg::ST_IDLE;
        endcase
        if (i_flush)
            state_next = rv_exec_pkg::ST_IDLE;
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state    <= rv_exec_pkg::ST_IDLE;
            ready    <= 1'b1;
            step_cnt <= '0;
        end
        else
        begin
            state    <= state_next;
            ready    <= (state_next == rv_exec_pkg::ST_IDLE);
            step_cnt <= (state == rv_exec_pkg::ST_BUSY) ? step_cnt + 1'b1 : '0;
        end
    end

    // ####################
    // input capture

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            store       <= 1'b0;
            reg_write   <= 1'b0;
            jal         <= 1'b0;
            branch      <= 1'b0;
            branch_pred <= 1'b0;
            group       <= rv_exec_pkg::GRP_ARITH;
        end
        else if (i_flush)
        begin
            store       <= 1'b0;
            reg_write   <= 1'b0;
            jal         <= 1'b0;
            branch      <= 1'b0;
            branch_pred <= 1'b0;
            group       <= rv_exec_pkg::GRP_ARITH;
        end
        else if (ready)
        begin
            store       <= i_store;
            reg_write   <= i_reg_write;
            jal         <= i_jal;
            branch      <= i_branch;
            branch_pred <= i_branch_pred;
            group       <= i_group;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (ready)
        begin
            op1          <= i_op1;
            op2          <= i_op2;
            reg_data2    <= i_reg_data2;
            op2_inverse  <= i_op2_inverse;
            add_override <= i_add_override;
            funct3       <= i_funct3;
            rd           <= i_rd;
            pc           <= i_pc;
            pc_next      <= i_pc_next;
            pc_target    <= i_pc_target;
            link         <= i_link;
        end
        else if (state == rv_exec_pkg::ST_BUSY)
            op2 <= {1'b0, op2[rv_exec_pkg::XLEN-1:1]};  // next multiplier bit
    end

    // ####################
    // datapath

    logic                               mul_run, mul_last, add_sub;
    logic [rv_exec_pkg::XLEN:0]         add_op1, add, partial;
    logic [rv_exec_pkg::XLEN-1:0]       add_op2, addend;
    logic                               eq, lts, ltu;
    logic [rv_exec_pkg::XLEN-1:0]       xor_res, or_res, and_res, shl_res, shr_res;
    logic [2*rv_exec_pkg::XLEN-1:0]     product;
    logic [rv_exec_pkg::XLEN-1:0]       alu_result;

    assign mul_run  = (state == rv_exec_pkg::ST_BUSY);
    assign mul_last = mul_run & (step_cnt == rv_exec_pkg::STEP_LAST);

    // first step starts from a zero partial sum
    assign add_op1 = !mul_run ? {1'b0, op1} : (step_cnt == '0) ? '0 : partial;
    assign add_op2 = mul_run ? addend : op2;
    // signed multiplier bit 31 weighs -2^31, mul and mulh only
    assign add_sub = mul_run ? (mul_last & ~funct3[1]) : op2_inverse;

    rv_adder u_adder
    (
        .i_sub          (add_sub),
        .i_op1          (add_op1),
        .i_op2          (add_op2),
        .o_add          (add),
        .o_eq           (eq),
        .o_lts          (lts),
        .o_ltu          (ltu)
    );

    rv_bitwise u_bitwise
    (
        .i_sra          (op2_inverse),
        .i_op1          (op1),
        .i_op2          (op2),
        .o_xor          (xor_res),
        .o_or           (or_res),
        .o_and          (and_res),
        .o_shl          (shl_res),
        .o_shr          (shr_res)
    );

    rv_multiplier u_multiplier
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_busy         (mul_run),
        .i_op1          (op1),
        .i_op2_lsb      (op2[0]),
        .i_add          (add),
        .i_funct3       (funct3[1:0]),
        .o_addend       (addend),
        .o_partial      (partial),
        .o_product      (product)
    );

    rv_alu_mux u_alu_mux
    (
        .i_group        (group),
        .i_funct3       (funct3),
        .i_add_override (add_override),
        .i_add          (add[rv_exec_pkg::XLEN-1:0]),
        .i_xor          (xor_res),
        .i_or           (or_res),
        .i_and          (and_res),
        .i_shl          (shl_res),
        .i_shr          (shr_res),
        .i_lts          (lts),
        .i_ltu          (ltu),
        .i_product      (product),
        .o_result       (alu_result)
    );

    rv_branch_unit u_branch_unit
    (
        .i_eq           (eq),
        .i_lts          (lts),
        .i_ltu          (ltu),
        .i_funct3       (funct3),
        .i_jal          (jal),
        .i_branch       (branch),
        .i_branch_pred  (branch_pred),
        .i_pc_next      (pc_next),
        .i_pc_target    (pc_target),
        .o_pc_select    (o_pc_select),
        .o_pc_target    (o_pc_target)
    );

    rv_store_align u_store_align
    (
        .i_funct3       (funct3[1:0]),
        .i_addr_lo      (add[1:0]),
        .i_reg_data2    (reg_data2),
        .o_wdata        (o_wdata),
        .o_wsel         (o_wsel)
    );

    assign o_result    = link ? pc_next : alu_result;  // jal/jalr write pc+4
    assign o_add       = add[rv_exec_pkg::XLEN-1:0];
    assign o_ready     = ready;
    assign o_store     = store;
    assign o_reg_write = reg_write;
    assign o_rd        = rd;
    assign o_pc        = pc;
    assign o_funct3    = funct3;

    a_ready_idle: assert property
    (
        @(posedge i_clk) disable iff (!i_arst_n)
        ready == (state == rv_exec_pkg::ST_IDLE)
    );

    a_done_once: assert property
    (
        @(posedge i_clk) disable iff (!i_arst_n)
        state == rv_exec_pkg::ST_DONE |=> state != rv_exec_pkg::ST_DONE
    );

endmodule

`default_nettype wire

// File: rtl/rv_store_align.sv
`default_nettype none

module rv_store_align
(
    input  wire  [1:0]                       i_funct3,
    input  wire  [1:0]                       i_addr_lo,
    input  wire  [rv_exec_pkg::XLEN-1:0]     i_reg_data2,
    output logic [rv_exec_pkg::XLEN-1:0]     o_wdata,
    output logic [3:0]                       o_wsel
);

    always_comb
    begin
        case (i_funct3)
            rv_exec_pkg::F3_SB[1:0]:
            begin
                o_wdata = {4{i_reg_data2[7:0]}};
                o_wsel  = 4'b0001 << i_addr_lo;
            end
            rv_exec_pkg::F3_SH[1:0]:
            begin
                o_wdata = {2{i_reg_data2[15:0]}};
                o_wsel  = i_addr_lo[1] ? 4'b1100 : 4'b0011;  // upper or lower half
            end
            rv_exec_pkg::F3_SW[1:0]:
            begin
                o_wdata = i_reg_data2;
                o_wsel  = 4'b1111;
            end
            default:
            begin
                o_wdata = i_reg_data2;
                o_wsel  = 4'b0000;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/rv_branch_unit.sv
`default_nettype none

module rv_branch_unit
(
    input  wire                                  i_eq,
    input  wire                                  i_lts,
    input  wire                                  i_ltu,
    input  wire  [2:0]                           i_funct3,
    input  wire                                  i_jal,
    input  wire                                  i_branch,
    input  wire                                  i_branch_pred,
    input  wire  [rv_exec_pkg::IADDR_BITS-1:0]   i_pc_next,
    input  wire  [rv_exec_pkg::IADDR_BITS-1:0]   i_pc_target,
    output logic                                 o_pc_select,
    output logic [rv_exec_pkg::IADDR_BITS-1:0]   o_pc_target
);

    logic cond;
    logic taken;

    always_comb
    begin
        case (i_funct3[2:1])
            2'b00:   cond = i_eq;   // beq/bne
            2'b10:   cond = i_lts;  // blt/bge
            default: cond = i_ltu;
        endcase
    end

    assign taken = i_jal | (i_branch & (cond ^ i_funct3[0]));

    // redirect only on a mispredict
    assign o_pc_select = taken ^ i_branch_pred;
    assign o_pc_target = taken ? i_pc_target : i_pc_next;

endmodule

`default_nettype wire

// File: rtl/rv_alu_mux.sv
`default_nettype none

module rv_alu_mux
(
    input  rv_exec_pkg::alu_group_e          i_group,
    input  wire  [2:0]                       i_funct3,
    input  wire                              i_add_override,
    input  wire  [rv_exec_pkg::XLEN-1:0]     i_add,
    input  wire  [rv_exec_pkg::XLEN-1:0]     i_xor,
    input  wire  [rv_exec_pkg::XLEN-1:0]     i_or,
    input  wire  [rv_exec_pkg::XLEN-1:0]     i_and,
    input  wire  [rv_exec_pkg::XLEN-1:0]     i_shl,
    input  wire  [rv_exec_pkg::XLEN-1:0]     i_shr,
    input  wire                              i_lts,
    input  wire                              i_ltu,
    input  wire  [2*rv_exec_pkg::XLEN-1:0]   i_product,
    output logic [rv_exec_pkg::XLEN-1:0]     o_result
);

    always_comb
    begin
        o_result = '0;
        if (i_add_override)
            o_result = i_add;  // address calc
        else
        begin
            case (i_group)
                rv_exec_pkg::GRP_ARITH: o_result = i_add;
                rv_exec_pkg::GRP_SHIFT: o_result = (i_funct3 == rv_exec_pkg::F3_SLL) ? i_shl : i_shr;
                rv_exec_pkg::GRP_BITS:
                begin
                    case (i_funct3)
                        rv_exec_pkg::F3_XOR: o_result = i_xor;
                        rv_exec_pkg::F3_OR:  o_result = i_or;
                        rv_exec_pkg::F3_AND: o_result = i_and;
                        default:             o_result = '0;
                    endcase
                end
                rv_exec_pkg::GRP_CMP:
                begin
                    if (i_funct3 == rv_exec_pkg::F3_SLT)
                        o_result = {{(rv_exec_pkg::XLEN-1){1'b0}}, i_lts};
                    else if (i_funct3 == rv_exec_pkg::F3_SLTU)
                        o_result = {{(rv_exec_pkg::XLEN-1){1'b0}}, i_ltu};
                end
                rv_exec_pkg::GRP_MUL:
                begin
                    if (i_funct3 == rv_exec_pkg::F3_MUL)
                        o_result = i_product[rv_exec_pkg::XLEN-1:0];
                    else
                        o_result = i_product[2*rv_exec_pkg::XLEN-1:rv_exec_pkg::XLEN];  // mulh*
                end
                default: o_result = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/rv_multiplier.sv
`default_nettype none

module rv_multiplier
(
    input  wire                              i_clk,
    input  wire                              i_arst_n,
    input  wire                              i_busy,
    input  wire  [rv_exec_pkg::XLEN-1:0]     i_op1,
    input  wire                              i_op2_lsb,
    input  wire  [rv_exec_pkg::XLEN:0]       i_add,
    input  wire  [1:0]                       i_funct3,
    output logic [rv_exec_pkg::XLEN-1:0]     o_addend,
    output logic [rv_exec_pkg::XLEN:0]       o_partial,
    output logic [2*rv_exec_pkg::XLEN-1:0]   o_product
);

    logic                           op1_signed;
    logic                           sum_top;
    logic [rv_exec_pkg::XLEN:0]     partial;
    logic [rv_exec_pkg::XLEN-1:0]   low_bits;

    // only MULHU treats the multiplicand as unsigned
    assign op1_signed = (i_funct3 != rv_exec_pkg::F3_MULHU[1:0]);

    assign o_addend = i_op2_lsb ? i_op1 : '0;

    // adder zero-extends its second operand; flipping bit 32 turns
    // that into a sign extension of a negative multiplicand
    assign sum_top = i_add[rv_exec_pkg::XLEN]
                   ^ (op1_signed & o_addend[rv_exec_pkg::XLEN-1]);

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            partial <= '0;
        else if (i_busy)
            partial <= {op1_signed & sum_top, sum_top, i_add[rv_exec_pkg::XLEN-1:1]};
    end

    always_ff @(posedge i_clk)
    begin
        if (i_busy)
            low_bits <= {i_add[0], low_bits[rv_exec_pkg::XLEN-1:1]};  // shifted-out sum bits
    end

    assign o_partial = partial;
    assign o_product = {partial[rv_exec_pkg::XLEN-1:0], low_bits};

    a_partial_hold: assert property
    (
        @(posedge i_clk) disable iff (!i_arst_n)
        !i_busy |=> $stable(partial)
    );

endmodule

`default_nettype wire

// File: rtl/rv_bitwise.sv
`default_nettype none

module rv_bitwise
(
    input  wire                              i_sra,
    input  wire  [rv_exec_pkg::XLEN-1:0]     i_op1,
    input  wire  [rv_exec_pkg::XLEN-1:0]     i_op2,
    output logic [rv_exec_pkg::XLEN-1:0]     o_xor,
    output logic [rv_exec_pkg::XLEN-1:0]     o_or,
    output logic [rv_exec_pkg::XLEN-1:0]     o_and,
    output logic [rv_exec_pkg::XLEN-1:0]     o_shl,
    output logic [rv_exec_pkg::XLEN-1:0]     o_shr
);

    logic [rv_exec_pkg::SHAMT_BITS-1:0] shamt;
    logic [rv_exec_pkg::XLEN-1:0]       srl_res;
    logic [rv_exec_pkg::XLEN-1:0]       sra_res;

    assign shamt = i_op2[rv_exec_pkg::SHAMT_BITS-1:0];

    assign o_xor = i_op1 ^ i_op2;
    assign o_or  = i_op1 | i_op2;
    assign o_and = i_op1 & i_op2;

    assign o_shl   = i_op1 << shamt;
    assign srl_res = i_op1 >> shamt;
    assign sra_res = $signed(i_op1) >>> shamt;  // kept apart so the sign survives

    assign o_shr = i_sra ? sra_res : srl_res;

endmodule

`default_nettype wire

// File: rtl/rv_adder.sv
`default_nettype none

module rv_adder
(
    input  wire                              i_sub,
    input  wire  [rv_exec_pkg::XLEN:0]       i_op1,
    input  wire  [rv_exec_pkg::XLEN-1:0]     i_op2,
    output logic [rv_exec_pkg::XLEN:0]       o_add,
    output logic                             o_eq,
    output logic                             o_lts,
    output logic                             o_ltu
);

    logic [rv_exec_pkg::XLEN:0] op2_ext;

    // invert all 33 bits so the carry lands in the top bit
    assign op2_ext = {1'b0, i_op2} ^ {(rv_exec_pkg::XLEN + 1){i_sub}};
    assign o_add   = i_op1 + op2_ext + {{rv_exec_pkg::XLEN{1'b0}}, i_sub};

    // flags only meaningful when subtracting
    assign o_eq  = (o_add[rv_exec_pkg::XLEN-1:0] == '0);
    assign o_ltu = o_add[rv_exec_pkg::XLEN];  // borrow
    assign o_lts = o_add[rv_exec_pkg::XLEN]
                 ^ i_op1[rv_exec_pkg::XLEN-1]
                 ^ i_op2[rv_exec_pkg::XLEN-1];

endmodule

`default_nettype wire

// File: rtl/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

    // ####################
    // widths

    localparam int XLEN       = 32;
    localparam int IADDR_BITS = 32;
    localparam int MUL_STEPS  = 32;
    localparam int SHAMT_BITS = $clog2(XLEN);
    localparam int STEP_BITS  = $clog2(MUL_STEPS);

    localparam logic [STEP_BITS-1:0] STEP_LAST = STEP_BITS'(MUL_STEPS - 1);

    // ####################
    // types

    typedef enum logic [2:0]
    {
        GRP_ARITH = 3'd0,
        GRP_SHIFT = 3'd1,
        GRP_BITS  = 3'd2,
        GRP_CMP   = 3'd3,
        GRP_MUL   = 3'd4
    } alu_group_e;

    typedef enum logic [1:0]
    {
        ST_IDLE = 2'd0,
        ST_BUSY = 2'd1,
        ST_DONE = 2'd2
    } exec_state_e;

    // ####################
    // funct3 codes

    localparam logic [2:0] F3_SLL    = 3'b001;
    localparam logic [2:0] F3_SLT    = 3'b010;
    localparam logic [2:0] F3_SLTU   = 3'b011;
    localparam logic [2:0] F3_XOR    = 3'b100;
    localparam logic [2:0] F3_OR     = 3'b110;
    localparam logic [2:0] F3_AND    = 3'b111;

    localparam logic [2:0] F3_MUL    = 3'b000;
    localparam logic [2:0] F3_MULHU  = 3'b011;

    localparam logic [2:0] F3_SB     = 3'b000;  // store sizes
    localparam logic [2:0] F3_SH     = 3'b001;
    localparam logic [2:0] F3_SW     = 3'b010;

endpackage

`default_nettype wire
